/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_capture
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
SIM_ARGS  ?= +verilator+error+limit+1000
FAIL_MSG  ?= Test FAILED
PASS_MSG  ?= Test OK

SOURCES := $(wildcard logic/*.sv tb/*.sv)

.PHONY: all compile run clean

all: run

compile: $(BUILD_DIR)/V$(TOP)

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	-$(BUILD_DIR)/V$(TOP) $(SIM_ARGS) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation reported a failure"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "simulation ended without a result"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* logic/capture_ctrl.sv */
module capture_ctrl
    import capture_pkg::*;
(
    input  logic       CLK,
    input  logic       RESET,
    input  logic       in_valid,
    input  sample_in_t in_sample,
    input  ptr_t       wr_ptr,
    input  count_t     fill_count,
    input  logic       drain_done,
    output logic       in_ready,
    output logic       wr_en,
    output logic       ring_clear,
    output ptr_t       win_start,
    output count_t     win_len,
    output logic       drain_go,
    output logic       busy
);

    cap_state_e state;
    logic       prev_trig;
    logic       accept;
    logic       trig_edge;
    logic       last_slot;
    logic       close_win;
    count_t     pre_cnt;

    assign in_ready = (state != DRAIN);
    assign busy     = (state != FILL);
    assign accept   = in_valid && in_ready;

    // a set flag after a clear one opens the window
    assign trig_edge = (state == FILL) && accept && in_sample.trig && !prev_trig;

    // the next write brings the window to RING_DEPTH-1 samples
    assign last_slot = (win_len == count_t'(RING_DEPTH - 2));

    assign close_win = (state == CAPTURE) && accept && (!in_sample.trig || last_slot);

    assign ring_clear = (state == DRAIN) && drain_done;

    // pre-trigger depth is limited by what the ring holds since it was emptied
    assign pre_cnt = (fill_count < count_t'(PRE_LEN)) ? fill_count : count_t'(PRE_LEN);

    always_comb
    begin
        case (state)
            FILL:    wr_en = accept;
            CAPTURE: wr_en = accept && in_sample.trig; // the closing clear sample is dropped
            default: wr_en = 1'b0;
        endcase
    end

    always_ff @(posedge CLK)
    begin
        if (!RESET)
        begin
            state     <= FILL;
            prev_trig <= 1'b0;
            win_len   <= '0;
            drain_go  <= 1'b0;
        end
        else
        begin
            drain_go <= close_win; // coincides with the first DRAIN cycle
            if (accept)
            begin
                prev_trig <= in_sample.trig;
            end
            case (state)
                FILL:
                begin
                    if (trig_edge)
                    begin
                        state   <= CAPTURE;
                        win_len <= pre_cnt + count_t'(1); // history plus the trigger sample
                    end
                end
                CAPTURE:
                begin
                    if (wr_en)
                    begin
                        win_len <= win_len + count_t'(1);
                    end
                    if (close_win)
                    begin
                        state <= DRAIN;
                    end
                end
                DRAIN:
                begin
                    if (drain_done)
                    begin
                        state <= FILL;
                    end
                end
                default:
                begin
                    state <= FILL;
                end
            endcase
        end
    end

    always_ff @(posedge CLK)
    begin
        if (trig_edge)
        begin
            win_start <= wr_ptr - pre_cnt[PTR_W-1:0];
        end
    end

endmodule

/* logic/capture_pkg.sv */
package capture_pkg;

    localparam int SAMPLE_W         = 32;
    localparam int WORD_W           = 8;
    localparam int WORDS_PER_SAMPLE = SAMPLE_W / WORD_W;
    localparam int RING_DEPTH       = 64;
    localparam int PRE_LEN          = 8;

    localparam int PTR_W  = $clog2(RING_DEPTH);       // ring address width
    localparam int CNT_W  = PTR_W + 1;                // holds 0 to RING_DEPTH
    localparam int WCNT_W = $clog2(WORDS_PER_SAMPLE); // word index inside a sample

    typedef logic [PTR_W-1:0] ptr_t;
    typedef logic [CNT_W-1:0] count_t;

    // one input sample with its trigger flag
    typedef struct packed {
        logic [SAMPLE_W-1:0] data;
        logic                trig;
    } sample_in_t;

    // one narrow output word, last marks the end of the window
    typedef struct packed {
        logic [WORD_W-1:0] data;
        logic              last;
    } word_out_t;

    // a sample on its way from the reader to the narrower
    typedef struct packed {
        logic [SAMPLE_W-1:0] data;
        logic                last;
    } reader_samp_t;

    typedef enum logic [1:0] {
        FILL,
        CAPTURE,
        DRAIN
    } cap_state_e;

endpackage

/* logic/capture_top.sv */
module capture_top
    import capture_pkg::*;
(
    input  logic       CLK,
    input  logic       RESET,
    input  logic       in_valid,
    input  sample_in_t in_sample,
    input  logic       out_ready,
    output logic       in_ready,
    output logic       out_valid,
    output word_out_t  out_word,
    output logic       busy
);

    logic                wr_en;
    logic                ring_clear;
    ptr_t                wr_ptr;
    count_t              fill_count;
    ptr_t                win_start;
    count_t              win_len;
    logic                drain_go;
    logic                drain_done;
    ptr_t                rd_addr;
    logic [SAMPLE_W-1:0] rd_data;
    logic                samp_valid;
    logic                samp_ready;
    reader_samp_t        samp;

    capture_ctrl u_ctrl (
        .CLK        (CLK),
        .RESET      (RESET),
        .in_valid   (in_valid),
        .in_sample  (in_sample),
        .wr_ptr     (wr_ptr),
        .fill_count (fill_count),
        .drain_done (drain_done),
        .in_ready   (in_ready),
        .wr_en      (wr_en),
        .ring_clear (ring_clear),
        .win_start  (win_start),
        .win_len    (win_len),
        .drain_go   (drain_go),
        .busy       (busy)
    );

    sample_ring u_ring (
        .CLK        (CLK),
        .RESET      (RESET),
        .wr_en      (wr_en),
        .wr_data    (in_sample.data),
        .ring_clear (ring_clear),
        .rd_addr    (rd_addr),
        .rd_data    (rd_data),
        .wr_ptr     (wr_ptr),
        .fill_count (fill_count)
    );

    window_reader u_reader (
        .CLK        (CLK),
        .RESET      (RESET),
        .drain_go   (drain_go),
        .win_start  (win_start),
        .win_len    (win_len),
        .rd_data    (rd_data),
        .samp_ready (samp_ready),
        .rd_addr    (rd_addr),
        .samp_valid (samp_valid),
        .samp       (samp),
        .drain_done (drain_done)
    );

    word_narrower u_narrower (
        .CLK        (CLK),
        .RESET      (RESET),
        .samp_valid (samp_valid),
        .samp       (samp),
        .out_ready  (out_ready),
        .samp_ready (samp_ready),
        .out_valid  (out_valid),
        .out_word   (out_word)
    );

endmodule

/* logic/sample_ring.sv */
module sample_ring
    import capture_pkg::*;
(
    input  logic                CLK,
    input  logic                RESET,
    input  logic                wr_en,
    input  logic [SAMPLE_W-1:0] wr_data,
    input  logic                ring_clear,
    input  ptr_t                rd_addr,
    output logic [SAMPLE_W-1:0] rd_data,
    output ptr_t                wr_ptr,
    output count_t              fill_count
);

    logic [SAMPLE_W-1:0] mem [RING_DEPTH];
    logic                fill_sat;

    // once the ring has wrapped it always holds RING_DEPTH-1 valid entries
    assign fill_sat = (fill_count == count_t'(RING_DEPTH - 1));

    always_ff @(posedge CLK)
    begin
        if (wr_en)
        begin
            mem[wr_ptr] <= wr_data;
        end
        rd_data <= mem[rd_addr]; // one cycle read latency
    end

    always_ff @(posedge CLK)
    begin
        if (!RESET)
        begin
            wr_ptr <= '0;
        end
        else if (wr_en)
        begin
            wr_ptr <= wr_ptr + ptr_t'(1); // wraps at RING_DEPTH
        end
    end

    always_ff @(posedge CLK)
    begin
        if (!RESET)
        begin
            fill_count <= '0;
        end
        else if (ring_clear)
        begin
            fill_count <= '0; // the pointer stays, only the history is forgotten
        end
        else if (wr_en && !fill_sat)
        begin
            fill_count <= fill_count + count_t'(1);
        end
    end

endmodule

/* logic/window_reader.sv */
module window_reader
    import capture_pkg::*;
(
    input  logic                CLK,
    input  logic                RESET,
    input  logic                drain_go,
    input  ptr_t                win_start,
    input  count_t              win_len,
    input  logic [SAMPLE_W-1:0] rd_data,
    input  logic                samp_ready,
    output ptr_t                rd_addr,
    output logic                samp_valid,
    output reader_samp_t        samp,
    output logic                drain_done
);

    ptr_t   rd_ptr;
    count_t remain;    // reads still to be issued
    logic   pending;   // a read was issued last cycle, rd_data is valid now
    logic   pend_last; // the read in flight is the final one of the window
    logic   issue;
    logic   samp_take;

    assign rd_addr   = rd_ptr;
    assign samp_take = samp_valid && samp_ready;

    // only read when the output slot is free by the time the data returns
    assign issue = (remain != '0) && !pending && (!samp_valid || samp_take);

    assign drain_done = samp_take && samp.last;

    always_ff @(posedge CLK)
    begin
        if (!RESET)
        begin
            rd_ptr     <= '0;
            remain     <= '0;
            pending    <= 1'b0;
            pend_last  <= 1'b0;
            samp_valid <= 1'b0;
        end
        else
        begin
            pending <= issue;
            if (drain_go)
            begin
                rd_ptr <= win_start;
                remain <= win_len;
            end
            else if (issue)
            begin
                rd_ptr    <= rd_ptr + ptr_t'(1); // wraps around the ring
                remain    <= remain - count_t'(1);
                pend_last <= (remain == count_t'(1));
            end
            if (pending)
            begin
                samp_valid <= 1'b1;
            end
            else if (samp_take)
            begin
                samp_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge CLK)
    begin
        if (pending)
        begin
            samp.data <= rd_data;
            samp.last <= pend_last;
        end
    end

endmodule

/* logic/word_narrower.sv */
module word_narrower
    import capture_pkg::*;
(
    input  logic         CLK,
    input  logic         RESET,
    input  logic         samp_valid,
    input  reader_samp_t samp,
    input  logic         out_ready,
    output logic         samp_ready,
    output logic         out_valid,
    output word_out_t    out_word
);

    logic [SAMPLE_W-1:0] shift_buf;
    logic [WCNT_W-1:0]   word_cnt;
    logic                buf_valid;
    logic                buf_last;
    logic                final_word;
    logic                samp_take;
    logic                word_take;

    assign final_word = (word_cnt == WCNT_W'(WORDS_PER_SAMPLE - 1));
    assign word_take  = buf_valid && out_ready;
    assign samp_take  = samp_valid && samp_ready;

    // a new sample can enter as the last word of the current one leaves
    assign samp_ready = !buf_valid || (out_ready && final_word);

    assign out_valid     = buf_valid;
    assign out_word.data = shift_buf[WORD_W-1:0];
    assign out_word.last = buf_last && final_word;

    always_ff @(posedge CLK)
    begin
        if (!RESET)
        begin
            buf_valid <= 1'b0;
            buf_last  <= 1'b0;
            word_cnt  <= '0;
        end
        else if (samp_take)
        begin
            buf_valid <= 1'b1;
            buf_last  <= samp.last;
            word_cnt  <= '0;
        end
        else if (word_take)
        begin
            if (final_word)
            begin
                buf_valid <= 1'b0;
            end
            else
            begin
                word_cnt <= word_cnt + WCNT_W'(1);
            end
        end
    end

    always_ff @(posedge CLK)
    begin
        if (samp_take)
        begin
            shift_buf <= samp.data;
        end
        else if (word_take)
        begin
            shift_buf <= shift_buf >> WORD_W; // least significant word goes first
        end
    end

endmodule

/* tb/capture_assertions.sv */
module capture_assertions
    import capture_pkg::*;
(
    input  logic       CLK,
    input  logic       RESET,
    input  cap_state_e state,
    input  logic       in_ready,
    input  logic       drain_go,
    input  logic       rd_pending,
    input  logic       samp_valid,
    input  logic       out_valid,
    input  logic       out_ready,
    input  word_out_t  out_word,
    output int         fail_count
);

    int drain_fails  = 0;
    int go_fails     = 0;
    int stable_fails = 0;

    assign fail_count = drain_fails + go_fails + stable_fails;

    // the ring must not take writes while window samples are read from it
    input_closed_in_drain: assert property (@(posedge CLK) disable iff (!RESET)
        (rd_pending || samp_valid) |-> !in_ready)
    else
    begin
        drain_fails++;
        $error("in_ready is high while window samples are read from the ring");
    end

    // drain_go lands on the first DRAIN cycle, right after CAPTURE, with the reader idle
    drain_go_on_close: assert property (@(posedge CLK) disable iff (!RESET)
        drain_go |-> (state == DRAIN) && ($past(state) == CAPTURE)
                     && !rd_pending && !samp_valid)
    else
    begin
        go_fails++;
        $error("drain_go outside the step from CAPTURE to DRAIN or with the reader busy");
    end

    word_held_on_stall: assert property (@(posedge CLK) disable iff (!RESET)
        out_valid && !out_ready |=> out_valid && $stable(out_word))
    else
    begin
        stable_fails++;
        $error("out_word changed or was dropped while out_ready was low");
    end

endmodule

bind capture_top capture_assertions u_assert (
    .CLK        (CLK),
    .RESET      (RESET),
    .state      (u_ctrl.state),
    .in_ready   (in_ready),
    .drain_go   (drain_go),
    .rd_pending (u_reader.pending),
    .samp_valid (samp_valid),
    .out_valid  (out_valid),
    .out_ready  (out_ready),
    .out_word   (out_word),
    .fail_count ()
);

/* tb/capture_checker.sv */
module capture_checker
    import capture_pkg::*;
(
    input  logic       CLK,
    input  logic       RESET,
    input  logic       in_valid,
    input  logic       in_ready,
    input  sample_in_t in_sample,
    input  logic       out_valid,
    input  logic       out_ready,
    input  word_out_t  out_word,
    input  logic       busy,
    output int         error_count
);

    logic [SAMPLE_W-1:0] history [$]; // newest samples stored since the ring was emptied
    logic [SAMPLE_W-1:0] window [$];
    word_out_t           expected [$];
    logic                prev_trig = 1'b0;
    logic                capturing = 1'b0;
    logic                draining  = 1'b0;
    int                  value_errors = 0;
    int                  flow_errors  = 0;
    int                  windows_seen = 0;

    assign error_count = value_errors + flow_errors;

    // cut the window into words, least significant first
    task automatic close_window();
        logic [SAMPLE_W-1:0] s;
        word_out_t           w;
        int                  i;
        int                  k;
        for (i = 0; i < window.size(); i++)
        begin
            s = window[i];
            for (k = 0; k < WORDS_PER_SAMPLE; k++)
            begin
                w.data = s[k*WORD_W +: WORD_W];
                w.last = (i == window.size() - 1) && (k == WORDS_PER_SAMPLE - 1);
                expected.push_back(w);
            end
        end
        windows_seen++;
        window.delete();
        history.delete(); // the ring is emptied once this window drains
        capturing = 1'b0;
        draining  = 1'b1;
    endtask

    task automatic report_totals(input int assert_fails);
        if (expected.size() != 0)
        begin
            flow_errors++;
            $display("missing output: %0d words of a window never came out", expected.size());
        end
        $display("checker: %0d windows, %0d wrong values, %0d flow errors, %0d assertion failures",
                 windows_seen, value_errors, flow_errors, assert_fails);
    endtask

    always @(posedge CLK)
    begin
        word_out_t exp_word;
        logic      exp_busy;
        logic      exp_ready;
        if (!RESET)
        begin
            history.delete();
            window.delete();
            prev_trig = 1'b0;
            capturing = 1'b0;
            draining  = 1'b0;
        end
        else
        begin
            // the drain ends once the window's last sample sits in the narrower
            if (draining && out_valid && expected.size() <= WORDS_PER_SAMPLE)
            begin
                draining = 1'b0;
            end
            exp_busy  = capturing || draining;
            exp_ready = !draining;
            if (busy !== exp_busy)
            begin
                value_errors++;
                $display("Fail at %0t: busy expected %b, got %b", $time, exp_busy, busy);
            end
            if (in_ready !== exp_ready)
            begin
                value_errors++;
                $display("Fail at %0t: in_ready expected %b, got %b",
                         $time, exp_ready, in_ready);
            end
            if (in_valid && in_ready && !draining)
            begin
                if (capturing)
                begin
                    if (in_sample.trig)
                    begin
                        window.push_back(in_sample.data);
                        if (window.size() == RING_DEPTH - 1)
                        begin
                            close_window(); // truncated window
                        end
                    end
                    else
                    begin
                        close_window(); // the clear sample is not stored
                    end
                end
                else if (in_sample.trig && !prev_trig)
                begin
                    window = history;
                    window.push_back(in_sample.data);
                    capturing = 1'b1;
                end
                else
                begin
                    history.push_back(in_sample.data);
                    if (history.size() > PRE_LEN)
                    begin
                        void'(history.pop_front());
                    end
                end
                prev_trig = in_sample.trig;
            end
            if (out_valid && out_ready)
            begin
                if (expected.size() == 0)
                begin
                    flow_errors++;
                    $display("at %0t an output word came out with no window pending", $time);
                end
                else
                begin
                    exp_word = expected.pop_front();
                    if (out_word.data !== exp_word.data)
                    begin
                        value_errors++;
                        $display("Fail at %0t: out_word.data expected %h, got %h",
                                 $time, exp_word.data, out_word.data);
                    end
                    if (out_word.last !== exp_word.last)
                    begin
                        value_errors++;
                        $display("Fail at %0t: out_word.last expected %b, got %b",
                                 $time, exp_word.last, out_word.last);
                    end
                end
            end
        end
    end

endmodule

/* tb/tb_capture.sv */
module tb_capture
    import capture_pkg::*;
();

    typedef struct packed {
        logic [7:0] n_clear;   // untriggered samples before the trigger
        logic [7:0] n_trig;    // samples with the flag set
        logic [7:0] stall_pat; // out_ready is low where a bit is set
        logic       rand_stall;
    } row_t;

    row_t rows [7] = '{
        '{8'd3,  8'd5,  8'h00, 1'b0}, // short history right after reset
        '{8'd20, 8'd6,  8'h00, 1'b0},
        '{8'd0,  8'd4,  8'h5a, 1'b0}, // trigger right after a drain, no history
        '{8'd5,  8'd3,  8'h00, 1'b1},
        '{8'd12, 8'd70, 8'h00, 1'b1}, // longer than the ring, gets truncated
        '{8'd2,  8'd7,  8'h33, 1'b0},
        '{8'd30, 8'd10, 8'h00, 1'b1}
    };

    logic        CLK = 1'b0;
    logic        RESET;
    logic        in_valid;
    sample_in_t  in_sample;
    logic        out_ready = 1'b0;
    logic        in_ready;
    logic        out_valid;
    word_out_t   out_word;
    logic        busy;
    int          error_count;
    int          row_idx = 0;
    int          cyc = 0;
    logic [31:0] stall_seed = 32'h27ab7e3b;

    always #10 CLK = ~CLK;

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic int total_samples();
        int n;
        n = 0;
        foreach (rows[r])
        begin
            n += int'(rows[r].n_clear) + int'(rows[r].n_trig) + 1;
        end
        return n;
    endfunction

    capture_top u_dut (
        .CLK       (CLK),
        .RESET     (RESET),
        .in_valid  (in_valid),
        .in_sample (in_sample),
        .out_ready (out_ready),
        .in_ready  (in_ready),
        .out_valid (out_valid),
        .out_word  (out_word),
        .busy      (busy)
    );

    capture_checker u_chk (
        .CLK         (CLK),
        .RESET       (RESET),
        .in_valid    (in_valid),
        .in_ready    (in_ready),
        .in_sample   (in_sample),
        .out_valid   (out_valid),
        .out_ready   (out_ready),
        .out_word    (out_word),
        .busy        (busy),
        .error_count (error_count)
    );

    always @(negedge CLK)
    begin
        stall_seed = lcg_next(stall_seed);
        cyc = cyc + 1;
        out_ready <= !rows[row_idx].stall_pat[cyc % 8] &&
                     !(rows[row_idx].rand_stall && stall_seed[17]);
    end

    // called on a falling edge, returns on the falling edge after the transfer
    task automatic offer_sample(input logic [SAMPLE_W-1:0] data, input logic trig);
        in_valid       = 1'b1;
        in_sample.data = data;
        in_sample.trig = trig;
        while (!in_ready)
        begin
            @(negedge CLK);
        end
        @(negedge CLK);
        in_valid = 1'b0;
    endtask

    initial
    begin
        logic [SAMPLE_W-1:0] data_seed;
        int                  r;
        int                  i;
        data_seed = 32'h27ab7e3b;
        RESET     = 1'b0;
        in_valid  = 1'b0;
        in_sample = '0;
        repeat (5) @(posedge CLK);
        @(negedge CLK);
        RESET = 1'b1;
        for (r = 0; r < $size(rows); r++)
        begin
            row_idx <= r;
            for (i = 0; i < rows[r].n_clear; i++)
            begin
                data_seed = lcg_next(data_seed);
                offer_sample(data_seed, 1'b0);
            end
            for (i = 0; i < rows[r].n_trig; i++)
            begin
                data_seed = lcg_next(data_seed);
                offer_sample(data_seed, 1'b1);
            end
            data_seed = lcg_next(data_seed);
            offer_sample(data_seed, 1'b0); // a clear flag ends the window
        end
        while (busy || out_valid)
        begin
            @(negedge CLK);
        end
        repeat (4) @(negedge CLK);
        u_chk.report_totals(u_dut.u_assert.fail_count);
        if (error_count == 0 && u_dut.u_assert.fail_count == 0)
        begin
            $display("Test OK");
        end
        else
        begin
            $display("Test FAILED");
        end
        $finish;
    end

    // roughly 30 cycles per sample covers the worst drain with stalls
    initial
    begin
        repeat (total_samples() * 30 + 1000) @(posedge CLK);
        $display("timeout: the run did not finish within %0d cycles",
                 total_samples() * 30 + 1000);
        u_chk.report_totals(u_dut.u_assert.fail_count);
        $display("Test FAILED");
        $finish;
    end

endmodule

/* verilog.f */
logic/capture_pkg.sv
logic/capture_ctrl.sv
logic/sample_ring.sv
logic/window_reader.sv
logic/word_narrower.sv
logic/capture_top.sv
tb/capture_assertions.sv
tb/capture_checker.sv
tb/tb_capture.sv
